// File: Makefile
# Verilator build and run for the battleship board engine
VERILATOR ?= verilator
TOP       ?= tb_battle_board
FILELIST  ?= battle_board_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Testbench failed
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) common/battle_defines.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || echo "$(FAIL_MSG): simulator exit status" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: battle_board_top.f
+incdir+common
common/game_pkg.sv
common/board_pkg.sv
hw/board_cmd_decode.sv
hw/board/board_store.sv
hw/fleet_tally.sv
hw/battle_board_top.sv
sim/battle_board_chk.sv
sim/tb_battle_board.sv

// File: common/battle_defines.svh
`ifndef BATTLE_DEFINES_SVH
`define BATTLE_DEFINES_SVH

// Square board side in cells
`define BOARD_DIM 5

`define COORD_W 3       // Row, column and ship length width
`define CNT_W 3         // Ships per side
`define CELL_W 2        // Bits per board cell

// Longest ship the store will ever draw
`define MAX_SHIP_LEN 5

`endif

// File: common/board_pkg.sv
`include "battle_defines.svh"

package board_pkg;

    // Bit 1 marks an attacked cell, bit 0 a ship
    typedef enum logic [`CELL_W-1:0] {
        WATER = 2'b00,
        SHIP  = 2'b01,
        MISS  = 2'b10,      // Attacked water
        HIT   = 2'b11       // Attacked ship
    } cell_state_e;

    typedef struct packed {
        logic attacked;
        logic ship;
    } cell_flags_s;

    // Same word seen as a named state or as two flag bits
    typedef union packed {
        cell_state_e state;
        cell_flags_s flags;
    } board_cell_u;

endpackage

// File: common/game_pkg.sv
package game_pkg;

    // Operation handed from decode to the board store
    typedef enum logic [1:0] {
        OP_NONE   = 2'b00,
        OP_PLACE  = 2'b01,  // Player ship, horizontal
        OP_SEED   = 2'b10,  // One computer ship cell
        OP_ATTACK = 2'b11   // Player fires on computer board
    } board_op_e;

    // Outcome of one attack on the computer board
    typedef enum logic [1:0] {
        RES_NONE   = 2'b00,
        RES_MISS   = 2'b01,
        RES_HIT    = 2'b10,
        RES_REPEAT = 2'b11  // Cell was already attacked
    } attack_result_e;

endpackage

// File: hw/battle_board_top.sv
`timescale 1ns/10ps
`include "battle_defines.svh"

module battle_board_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     i_place_phase,
    input  logic                                     i_setup_phase,
    input  logic                                     i_attack_phase,
    input  logic                                     i_confirm_place,
    input  logic                                     i_confirm_attack,
    input  logic [`COORD_W-1:0]                      i_row,
    input  logic [`COORD_W-1:0]                      i_col,
    input  logic [`COORD_W-1:0]                      i_ship_len,
    input  logic [`COORD_W-1:0]                      i_rand_row,
    input  logic [`COORD_W-1:0]                      i_rand_col,
    input  logic [`CNT_W-1:0]                        i_ship_target,
    output logic [`BOARD_DIM*`BOARD_DIM*`CELL_W-1:0] o_player_board,
    output logic [`BOARD_DIM*`BOARD_DIM*`CELL_W-1:0] o_pc_board,
    output logic [`CNT_W-1:0]                        o_player_count,
    output logic [`CNT_W-1:0]                        o_pc_count,
    output logic                                     o_placing_done,
    output logic                                     o_setup_done,
    output logic                                     o_fleet_sunk,
    output game_pkg::attack_result_e                 o_last_result
);

    game_pkg::board_op_e       op_kind;
    logic [`COORD_W-1:0]       op_row;
    logic [`COORD_W-1:0]       op_col;
    logic [`COORD_W-1:0]       op_len;
    logic                      placed_pulse;
    logic                      seeded_pulse;
    game_pkg::attack_result_e  attack_result;

    board_cmd_decode u_decode (
        .clk              (clk),
        .rst              (rst),
        .i_place_phase    (i_place_phase),
        .i_setup_phase    (i_setup_phase),
        .i_attack_phase   (i_attack_phase),
        .i_confirm_place  (i_confirm_place),
        .i_confirm_attack (i_confirm_attack),
        .i_row            (i_row),
        .i_col            (i_col),
        .i_ship_len       (i_ship_len),
        .i_rand_row       (i_rand_row),
        .i_rand_col       (i_rand_col),
        .i_ship_target    (i_ship_target),
        .i_player_count   (o_player_count),   // Counts gate place and seed
        .i_pc_count       (o_pc_count),
        .o_op_kind        (op_kind),
        .o_op_row         (op_row),
        .o_op_col         (op_col),
        .o_op_len         (op_len)
    );

    board_store u_store (
        .clk             (clk),
        .rst             (rst),
        .i_op_kind       (op_kind),
        .i_op_row        (op_row),
        .i_op_col        (op_col),
        .i_op_len        (op_len),
        .o_player_board  (o_player_board),
        .o_pc_board      (o_pc_board),
        .o_placed        (placed_pulse),
        .o_seeded        (seeded_pulse),
        .o_attack_result (attack_result)
    );

    fleet_tally u_tally (
        .clk             (clk),
        .rst             (rst),
        .i_place_phase   (i_place_phase),
        .i_setup_phase   (i_setup_phase),
        .i_attack_phase  (i_attack_phase),
        .i_ship_target   (i_ship_target),
        .i_placed        (placed_pulse),
        .i_seeded        (seeded_pulse),
        .i_attack_result (attack_result),
        .o_player_count  (o_player_count),
        .o_pc_count      (o_pc_count),
        .o_placing_done  (o_placing_done),
        .o_setup_done    (o_setup_done),
        .o_fleet_sunk    (o_fleet_sunk),
        .o_last_result   (o_last_result)
    );

endmodule

// File: hw/board/board_store.sv
`timescale 1ns/10ps
`include "battle_defines.svh"

module board_store (
    input  logic                                     clk,
    input  logic                                     rst,
    input  game_pkg::board_op_e                      i_op_kind,
    input  logic [`COORD_W-1:0]                      i_op_row,
    input  logic [`COORD_W-1:0]                      i_op_col,
    input  logic [`COORD_W-1:0]                      i_op_len,
    output logic [`BOARD_DIM*`BOARD_DIM*`CELL_W-1:0] o_player_board,
    output logic [`BOARD_DIM*`BOARD_DIM*`CELL_W-1:0] o_pc_board,
    output logic                                     o_placed,
    output logic                                     o_seeded,
    output game_pkg::attack_result_e                 o_attack_result
);

    localparam int CELLS = `BOARD_DIM * `BOARD_DIM;
    localparam int IDX_W = $clog2(CELLS);

    board_pkg::board_cell_u player_board [CELLS];
    board_pkg::board_cell_u pc_board     [CELLS];

    logic [IDX_W-1:0] op_idx;
    board_pkg::board_cell_u target_cell;

    // Row major, cell (row, col) at row*DIM + col
    assign op_idx = IDX_W'(i_op_row * `BOARD_DIM + i_op_col);
    assign target_cell = pc_board[op_idx];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < CELLS; i++) begin
                player_board[i].state <= board_pkg::WATER;
                pc_board[i].state     <= board_pkg::WATER;
            end
            o_placed        <= 1'b0;
            o_seeded        <= 1'b0;
            o_attack_result <= game_pkg::RES_NONE;
        end else begin
            o_placed        <= 1'b0;
            o_seeded        <= 1'b0;
            o_attack_result <= game_pkg::RES_NONE;
            case (i_op_kind)
                game_pkg::OP_PLACE: begin
                    for (int k = 0; k < `MAX_SHIP_LEN; k++) begin
                        // Cells beyond the right edge are dropped
                        if ((k < int'(i_op_len)) && (int'(i_op_col) + k < `BOARD_DIM)) begin
                            player_board[int'(op_idx) + k].state <= board_pkg::SHIP;
                        end
                    end
                    o_placed <= 1'b1;
                end
                game_pkg::OP_SEED: begin
                    if (target_cell.state == board_pkg::WATER) begin
                        pc_board[op_idx].state <= board_pkg::SHIP;
                        o_seeded <= 1'b1;
                    end
                end
                game_pkg::OP_ATTACK: begin
                    if (target_cell.flags.attacked) begin
                        o_attack_result <= game_pkg::RES_REPEAT;      // Board untouched
                    end else if (target_cell.flags.ship) begin
                        pc_board[op_idx].state <= board_pkg::HIT;
                        o_attack_result <= game_pkg::RES_HIT;
                    end else begin
                        pc_board[op_idx].state <= board_pkg::MISS;
                        o_attack_result <= game_pkg::RES_MISS;
                    end
                end
                default: ;
            endcase
        end
    end

    // Flatten both boards for the outside world
    genvar g;
    generate
        for (g = 0; g < CELLS; g++) begin : g_flat
            assign o_player_board[g*`CELL_W +: `CELL_W] = player_board[g];
            assign o_pc_board[g*`CELL_W +: `CELL_W]     = pc_board[g];
        end
    endgenerate

endmodule

// File: hw/board_cmd_decode.sv
`timescale 1ns/10ps
`include "battle_defines.svh"

module board_cmd_decode (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_place_phase,
    input  logic                  i_setup_phase,
    input  logic                  i_attack_phase,
    input  logic                  i_confirm_place,
    input  logic                  i_confirm_attack,
    input  logic [`COORD_W-1:0]   i_row,
    input  logic [`COORD_W-1:0]   i_col,
    input  logic [`COORD_W-1:0]   i_ship_len,
    input  logic [`COORD_W-1:0]   i_rand_row,
    input  logic [`COORD_W-1:0]   i_rand_col,
    input  logic [`CNT_W-1:0]     i_ship_target,
    input  logic [`CNT_W-1:0]     i_player_count,
    input  logic [`CNT_W-1:0]     i_pc_count,
    output game_pkg::board_op_e   o_op_kind,
    output logic [`COORD_W-1:0]   o_op_row,
    output logic [`COORD_W-1:0]   o_op_col,
    output logic [`COORD_W-1:0]   o_op_len
);

    localparam int unsigned DIM = `BOARD_DIM;

    logic                  place_q, setup_q, attack_q;
    logic                  cp_q, cp_qq;                 // Place button history
    logic                  ca_q, ca_qq;                 // Attack button history
    logic [`COORD_W-1:0]   row_q, col_q, len_q;
    logic [`COORD_W-1:0]   rrow_q, rcol_q;
    game_pkg::board_op_e   stage2_kind;                 // Op now inside the store
    game_pkg::board_op_e   op_nxt;
    logic [`COORD_W-1:0]   row_nxt, col_nxt;
    logic [`CNT_W:0]       place_load, seed_load;
    logic                  place_fall, attack_fall;
    logic                  player_in_range, rand_in_range;
    logic                  place_room, seed_room;

    always_ff @(posedge clk) begin
        if (!rst) begin
            place_q     <= 1'b0;
            setup_q     <= 1'b0;
            attack_q    <= 1'b0;
            cp_q        <= 1'b0;
            cp_qq       <= 1'b0;
            ca_q        <= 1'b0;
            ca_qq       <= 1'b0;
            o_op_kind   <= game_pkg::OP_NONE;
            stage2_kind <= game_pkg::OP_NONE;
        end else begin
            place_q     <= i_place_phase;
            setup_q     <= i_setup_phase;
            attack_q    <= i_attack_phase;
            cp_q        <= i_confirm_place;
            cp_qq       <= cp_q;
            ca_q        <= i_confirm_attack;
            ca_qq       <= ca_q;
            o_op_kind   <= op_nxt;
            stage2_kind <= o_op_kind;
        end
    end

    // Coordinates and length ride along with the sampled levels
    always_ff @(posedge clk) begin
        row_q    <= i_row;
        col_q    <= i_col;
        len_q    <= i_ship_len;
        rrow_q   <= i_rand_row;
        rcol_q   <= i_rand_col;
        o_op_row <= row_nxt;
        o_op_col <= col_nxt;
        o_op_len <= len_q;
    end

    assign place_fall  = cp_qq & ~cp_q;
    assign attack_fall = ca_qq & ~ca_q;

    assign player_in_range = (row_q < DIM) && (col_q < DIM);
    assign rand_in_range   = (rrow_q < DIM) && (rcol_q < DIM);

    // Count the ships still in flight so the target is never overshot
    assign place_load = {1'b0, i_player_count}
                      + {{`CNT_W{1'b0}}, (o_op_kind == game_pkg::OP_PLACE)}
                      + {{`CNT_W{1'b0}}, (stage2_kind == game_pkg::OP_PLACE)};
    assign seed_load  = {1'b0, i_pc_count}
                      + {{`CNT_W{1'b0}}, (o_op_kind == game_pkg::OP_SEED)}
                      + {{`CNT_W{1'b0}}, (stage2_kind == game_pkg::OP_SEED)};

    assign place_room = place_load < {1'b0, i_ship_target};
    assign seed_room  = seed_load < {1'b0, i_ship_target};

    always_comb begin
        op_nxt  = game_pkg::OP_NONE;
        row_nxt = row_q;
        col_nxt = col_q;
        if (place_q) begin                              // Place phase wins
            if (place_fall && place_room && player_in_range && (len_q != '0)) begin
                op_nxt = game_pkg::OP_PLACE;
            end
        end else if (setup_q) begin
            if (seed_room && rand_in_range) begin
                op_nxt  = game_pkg::OP_SEED;
                row_nxt = rrow_q;
                col_nxt = rcol_q;
            end
        end else if (attack_q && attack_fall && player_in_range) begin
            op_nxt = game_pkg::OP_ATTACK;
        end
    end

endmodule

// File: hw/fleet_tally.sv
`timescale 1ns/10ps
`include "battle_defines.svh"

module fleet_tally (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_place_phase,
    input  logic                      i_setup_phase,
    input  logic                      i_attack_phase,
    input  logic [`CNT_W-1:0]         i_ship_target,
    input  logic                      i_placed,
    input  logic                      i_seeded,
    input  game_pkg::attack_result_e  i_attack_result,
    output logic [`CNT_W-1:0]         o_player_count,
    output logic [`CNT_W-1:0]         o_pc_count,
    output logic                      o_placing_done,
    output logic                      o_setup_done,
    output logic                      o_fleet_sunk,
    output game_pkg::attack_result_e  o_last_result
);

    logic [`CNT_W-1:0] player_nxt;
    logic [`CNT_W-1:0] pc_nxt;

    always_comb begin
        player_nxt = o_player_count;
        pc_nxt     = o_pc_count;
        if (i_placed) begin
            player_nxt = o_player_count + 1'b1;
        end
        if (i_seeded) begin
            pc_nxt = o_pc_count + 1'b1;
        end else if (i_attack_result == game_pkg::RES_HIT) begin
            pc_nxt = o_pc_count - 1'b1;         // One computer ship cell lost
        end
    end

    // Flags are taken from the next counts so they land with the counters
    always_ff @(posedge clk) begin
        if (!rst) begin
            o_player_count <= '0;
            o_pc_count     <= '0;
            o_placing_done <= 1'b0;
            o_setup_done   <= 1'b0;
            o_fleet_sunk   <= 1'b0;
            o_last_result  <= game_pkg::RES_NONE;
        end else begin
            o_player_count <= player_nxt;
            o_pc_count     <= pc_nxt;
            o_placing_done <= i_place_phase && (player_nxt == i_ship_target);
            o_setup_done   <= i_setup_phase && (pc_nxt == i_ship_target);
            o_fleet_sunk   <= i_attack_phase && (i_ship_target != '0) && (pc_nxt == '0);
            if (i_attack_result != game_pkg::RES_NONE) begin
                o_last_result <= i_attack_result;   // Hold until next attack
            end
        end
    end

endmodule

// File: sim/battle_board_chk.sv
`timescale 1ns/10ps
`include "battle_defines.svh"

module battle_board_chk (
    input logic                                     clk,
    input logic                                     rst,
    input logic                                     i_attack_phase,
    input logic [`CNT_W-1:0]                        i_ship_target,
    input logic [`CNT_W-1:0]                        o_player_count,
    input logic [`CNT_W-1:0]                        o_pc_count,
    input logic [`BOARD_DIM*`BOARD_DIM*`CELL_W-1:0] o_pc_board,
    input logic                                     o_placing_done,
    input logic                                     o_setup_done,
    input logic                                     o_fleet_sunk,
    input game_pkg::attack_result_e                 o_last_result
);

    int unsigned fail_cnt = 0;

    // True while any computer cell still holds an unhit ship
    function automatic logic ship_left(input logic [`BOARD_DIM*`BOARD_DIM*`CELL_W-1:0] b);
        logic found;
        found = 1'b0;
        for (int i = 0; i < `BOARD_DIM*`BOARD_DIM; i++) begin
            if (b[i*`CELL_W +: `CELL_W] == board_pkg::SHIP) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Synchronous reset clears every flag on the next edge
    reset_clears: assert property (@(posedge clk) !rst |=> (!o_placing_done && !o_setup_done
            && !o_fleet_sunk && o_last_result == game_pkg::RES_NONE))
        else begin
            $error("Flags or last result not cleared during reset");
            fail_cnt++;
        end

    player_bound: assert property (@(posedge clk) disable iff (!rst)
            o_player_count <= i_ship_target)
        else begin
            $error("Player ship count went above the target");
            fail_cnt++;
        end

    pc_bound: assert property (@(posedge clk) disable iff (!rst)
            o_pc_count <= i_ship_target)
        else begin
            $error("Computer ship count went above the target");
            fail_cnt++;
        end

    // Only hits move the count while attacking
    pc_no_rise: assert property (@(posedge clk) disable iff (!rst)
            (i_attack_phase && $past(i_attack_phase)) |-> (o_pc_count <= $past(o_pc_count)))
        else begin
            $error("Computer ship count rose during the attack phase");
            fail_cnt++;
        end

    // Sunk fleet leaves a zero count and no ship cell on the board
    sunk_means_empty: assert property (@(posedge clk) disable iff (!rst)
            o_fleet_sunk |-> (o_pc_count == '0 && !ship_left(o_pc_board)))
        else begin
            $error("Fleet reported sunk with ships left");
            fail_cnt++;
        end

endmodule

// File: sim/tb_battle_board.sv
`timescale 1ns/10ps
`include "battle_defines.svh"

module tb_battle_board;

    localparam int DIM        = `BOARD_DIM;
    localparam int CW         = `COORD_W;
    localparam int BW         = `BOARD_DIM * `BOARD_DIM * `CELL_W;
    localparam int TARGET     = 4;
    localparam int MAX_CYCLES = 2000;

    logic                     clk, rst;
    logic                     i_place_phase, i_setup_phase, i_attack_phase;
    logic                     i_confirm_place, i_confirm_attack;
    logic [`COORD_W-1:0]      i_row, i_col, i_ship_len, i_rand_row, i_rand_col;
    logic [`CNT_W-1:0]        i_ship_target;
    logic [BW-1:0]            o_player_board, o_pc_board;
    logic [`CNT_W-1:0]        o_player_count, o_pc_count;
    logic                     o_placing_done, o_setup_done, o_fleet_sunk;
    game_pkg::attack_result_e o_last_result;

    logic [BW-1:0]            player_m, pc_m;       // Reference boards
    int                       player_cnt_m, pc_cnt_m;
    game_pkg::attack_result_e result_m;
    logic [31:0]              lfsr;
    logic [7:0]               r_row, r_col;
    int                       err_cnt = 0;
    int                       cycles = 0;
    int                       ship_cells;

    battle_board_top u_battle_board_top (.*);

    bind battle_board_top battle_board_chk u_chk (
        .clk(clk), .rst(rst), .i_attack_phase(i_attack_phase),
        .i_ship_target(i_ship_target), .o_player_count(o_player_count),
        .o_pc_count(o_pc_count), .o_pc_board(o_pc_board),
        .o_placing_done(o_placing_done), .o_setup_done(o_setup_done),
        .o_fleet_sunk(o_fleet_sunk), .o_last_result(o_last_result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic log_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [`CELL_W-1:0] cell_of(input logic [BW-1:0] b, input int r,
                                                   input int c);
        return b[(r*DIM + c)*`CELL_W +: `CELL_W];
    endfunction

    task automatic compare_outputs(input string step);
        assert (o_player_board == player_m) else log_error($sformatf(
            "%s: player board %h, expected %h", step, o_player_board, player_m));
        assert (o_pc_board == pc_m) else log_error($sformatf(
            "%s: computer board %h, expected %h", step, o_pc_board, pc_m));
        assert (o_player_count == player_cnt_m[`CNT_W-1:0]) else log_error($sformatf(
            "%s: player count %0d, expected %0d", step, o_player_count, player_cnt_m));
        assert (o_pc_count == pc_cnt_m[`CNT_W-1:0]) else log_error($sformatf(
            "%s: computer count %0d, expected %0d", step, o_pc_count, pc_cnt_m));
        assert (o_last_result == result_m) else log_error($sformatf(
            "%s: last result %s, expected %s", step, o_last_result.name(), result_m.name()));
        assert (o_placing_done == (i_place_phase && player_cnt_m == TARGET))
            else log_error($sformatf("%s: placing done flag wrong", step));
        assert (o_setup_done == (i_setup_phase && pc_cnt_m == TARGET))
            else log_error($sformatf("%s: setup done flag wrong", step));
        assert (o_fleet_sunk == (i_attack_phase && pc_cnt_m == 0))
            else log_error($sformatf("%s: fleet sunk flag wrong", step));
    endtask

    task automatic place_ship(input int r, input int c, input int len, input int hold);
        int k;
        i_row           = CW'(r);
        i_col           = CW'(c);
        i_ship_len      = CW'(len);
        i_confirm_place = 1'b0;
        tick(hold);                                 // Button held low
        i_confirm_place = 1'b1;
        tick(4);
        if (player_cnt_m < TARGET) begin
            for (k = 0; k < len; k++) begin
                if (c + k < DIM) player_m[(r*DIM + c + k)*`CELL_W +: `CELL_W] = board_pkg::SHIP;
            end
            player_cnt_m++;
        end
        compare_outputs("place");
    endtask

    // Each coordinate is held long enough for one seed to settle
    task automatic offer_seed(input int r, input int c);
        i_rand_row = CW'(r);
        i_rand_col = CW'(c);
        tick(4);
        if (r < DIM && c < DIM && pc_cnt_m < TARGET && cell_of(pc_m, r, c) == board_pkg::WATER) begin
            pc_m[(r*DIM + c)*`CELL_W +: `CELL_W] = board_pkg::SHIP;
            pc_cnt_m++;
        end
    endtask

    task automatic attack(input int r, input int c);
        int idx;
        i_row            = CW'(r);
        i_col            = CW'(c);
        i_confirm_attack = 1'b0;
        tick(1);
        i_confirm_attack = 1'b1;
        tick(4);
        if (r < DIM && c < DIM) begin
            idx = (r*DIM + c)*`CELL_W;
            case (cell_of(pc_m, r, c))
                board_pkg::SHIP: begin
                    pc_m[idx +: `CELL_W] = board_pkg::HIT;
                    pc_cnt_m--;
                    result_m = game_pkg::RES_HIT;
                end
                board_pkg::WATER: begin
                    pc_m[idx +: `CELL_W] = board_pkg::MISS;
                    result_m = game_pkg::RES_MISS;
                end
                default: result_m = game_pkg::RES_REPEAT;
            endcase
        end
        compare_outputs("attack");
    endtask

    initial begin
        lfsr             = 32'h1ab2;
        player_m         = '0;
        pc_m             = '0;
        player_cnt_m     = 0;
        pc_cnt_m         = 0;
        result_m         = game_pkg::RES_NONE;
        rst              = 1'b0;
        i_place_phase    = 1'b0;
        i_setup_phase    = 1'b0;
        i_attack_phase   = 1'b0;
        i_confirm_place  = 1'b1;                    // Buttons idle high
        i_confirm_attack = 1'b1;
        i_row            = '0;
        i_col            = '0;
        i_ship_len       = '0;
        i_rand_row       = '0;
        i_rand_col       = '0;
        i_ship_target    = `CNT_W'(TARGET);
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b1;
        tick(1);
        compare_outputs("reset");

        i_place_phase = 1'b1;
        place_ship(0, 0, 1, 1);
        place_ship(1, 1, 2, 5);
        place_ship(2, 3, 3, 1);                     // Runs off the right edge
        place_ship(4, 0, 3, 1);
        place_ship(3, 0, 2, 1);                     // Fleet already full
        i_place_phase = 1'b0;
        tick(2);

        i_setup_phase = 1'b1;
        offer_seed(6, 2);
        offer_seed(1, 1);
        offer_seed(1, 1);
        while (pc_cnt_m < TARGET) begin
            take_bits(3, r_row);
            take_bits(3, r_col);
            offer_seed(r_row, r_col);
        end
        while (!o_setup_done) tick(1);
        compare_outputs("setup");
        ship_cells = 0;
        for (int i = 0; i < DIM*DIM; i++) begin
            if (o_pc_board[i*`CELL_W +: `CELL_W] == board_pkg::SHIP) ship_cells++;
        end
        assert (ship_cells == TARGET) else log_error($sformatf(
            "computer board holds %0d ships, expected %0d", ship_cells, TARGET));
        i_setup_phase = 1'b0;
        tick(2);

        i_attack_phase = 1'b1;
        repeat (10) begin
            take_bits(3, r_row);
            take_bits(3, r_col);
            attack(r_row, r_col);
        end
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                if (cell_of(pc_m, r, c) == board_pkg::SHIP) begin
                    attack(r, c);
                    attack(r, c);                   // Second shot is a repeat
                end
            end
        end
        assert (o_fleet_sunk) else log_error("fleet sunk flag low after last hit");

        tick(2);
        $display("Errors: %0d, assertion failures: %0d", err_cnt,
                 u_battle_board_top.u_chk.fail_cnt);
        if (err_cnt == 0 && u_battle_board_top.u_chk.fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
